//--- sim.f
hw/isa_pkg.sv
hw/issue_pkg.sv
hw/gpr_file.sv
hw/operand_hazard.sv
hw/fu_dispatch.sv
hw/issue_read_operands.sv
bench/issue_read_operands_assert.sv
bench/tb_issue_read_operands.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the issue stage testbench with verilator, run it and check the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_issue_read_operands \
  -f sim.f -Mdir obj_dir || exit 1
./obj_dir/Vtb_issue_read_operands | tee /dev/stderr | grep -F "ALL CHECKS PASSED" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- bench/tb_issue_read_operands.sv
// --------------------
// testbench for the integer issue and read-operands stage
// fills the register file over commit and then applies a table of entries
// one row per cycle and checks ack, stall, operands and unit valids
// --------------------
`timescale 1ns/1ps

module tb_issue_read_operands
  import isa_pkg::*;
  import issue_pkg::*;
;

  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned TIMEOUT_CYCLES  = 50;

  // one table row
  typedef struct packed {
    fu_t        fu;
    fu_op_t     op;
    logic [4:0] rs1;
    logic [4:0] rs2;
    // use_pc, use_imm, use_zimm, ex_valid
    logic [3:0] flags;
    // pending writer of rs1 and rs2
    fu_t        clob1;
    fu_t        clob2;
    logic [1:0] fwd_valid;
    // flu ready, lsu ready, stall, flush
    logic [3:0] ready;
    logic       exp_ack;
    // alu, branch, mult, lsu, csr
    logic [4:0] exp_valid;
  } row_t;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               flush_i;
  logic                               stall_i;
  issue_entry_t                       issue_instr_i;
  logic                               issue_instr_valid_i;
  logic                               issue_ack_o;
  logic         [REG_ADDR_W-1:0]      rs1_o;
  logic         [REG_ADDR_W-1:0]      rs2_o;
  logic         [XLEN-1:0]            rs1_i;
  logic         [XLEN-1:0]            rs2_i;
  logic                               rs1_valid_i;
  logic                               rs2_valid_i;
  clobber_t                           rd_clobber_i;
  fu_data_t                           fu_data_o;
  logic         [XLEN-1:0]            rs1_forwarding_o;
  logic         [XLEN-1:0]            rs2_forwarding_o;
  logic         [XLEN-1:0]            pc_o;
  logic                               flu_ready_i;
  logic                               lsu_ready_i;
  logic         [4:0]                 valids;
  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i;
  logic                               stall_issue_o;

  row_t        rows[$];
  // register file model where x0 stays zero
  logic [31:0] shadow[32];
  logic [31:0] lfsr_q;
  int          errors;
  int          timeouts;

  issue_read_operands #(
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) u_issue_read_operands (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .stall_i             (stall_i),
    .issue_instr_i       (issue_instr_i),
    .issue_instr_valid_i (issue_instr_valid_i),
    .issue_ack_o         (issue_ack_o),
    .rs1_o               (rs1_o),
    .rs1_i               (rs1_i),
    .rs1_valid_i         (rs1_valid_i),
    .rs2_o               (rs2_o),
    .rs2_i               (rs2_i),
    .rs2_valid_i         (rs2_valid_i),
    .rd_clobber_i        (rd_clobber_i),
    .fu_data_o           (fu_data_o),
    .rs1_forwarding_o    (rs1_forwarding_o),
    .rs2_forwarding_o    (rs2_forwarding_o),
    .pc_o                (pc_o),
    .flu_ready_i         (flu_ready_i),
    .lsu_ready_i         (lsu_ready_i),
    .alu_valid_o         (valids[4]),
    .branch_valid_o      (valids[3]),
    .mult_valid_o        (valids[2]),
    .lsu_valid_o         (valids[1]),
    .csr_valid_o         (valids[0]),
    .commit_i            (commit_i),
    .stall_issue_o       (stall_issue_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------
  // helpers
  // --------------------
  // fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
  task automatic next_rand(output logic [31:0] value);
    logic fb;
    for (int b = 0; b < 32; b++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      value  = {value[30:0], fb};
    end
  endtask

  task automatic wrong_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    errors++;
  endtask

  task automatic add_row(input fu_t fu, input fu_op_t op, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [3:0] flags, input fu_t clob1,
                         input fu_t clob2, input logic [1:0] fwd_valid,
                         input logic [3:0] ready, input logic exp_ack,
                         input logic [4:0] exp_valid);
    rows.push_back(row_t'{fu, op, rs1, rs2, flags, clob1, clob2, fwd_valid, ready,
                          exp_ack, exp_valid});
  endtask

  // a source waits unless its writer can forward
  function automatic logic src_blocked(input fu_t clob, input logic valid, input fu_op_t op);
    return (clob != NONE) && !(valid && ((clob != CSR) || (op == SFENCE_VMA)));
  endfunction

  // both ports write at the same edge and the model applies port 1 last
  task automatic drive_commit(input logic [4:0] addr0, input logic [31:0] data0,
                              input logic [4:0] addr1, input logic [31:0] data1);
    commit_i[0].waddr = addr0;
    commit_i[0].wdata = data0;
    commit_i[0].we    = 1'b1;
    commit_i[1].waddr = addr1;
    commit_i[1].wdata = data1;
    commit_i[1].we    = 1'b1;
    if (addr0 != 5'd0) shadow[addr0] = data0;
    if (addr1 != 5'd0) shadow[addr1] = data1;
    @(posedge clk_i);
    #2;
  endtask

  task automatic drive_row(input row_t entry, input logic [31:0] pc,
                           input logic [31:0] imm, input logic [2:0] tid);
    issue_instr_i.pc       = pc;
    issue_instr_i.rs1      = entry.rs1;
    issue_instr_i.rs2      = entry.rs2;
    issue_instr_i.rd       = 5'd1;
    issue_instr_i.result   = imm;
    issue_instr_i.fu       = entry.fu;
    issue_instr_i.op       = entry.op;
    issue_instr_i.trans_id = tid;
    {issue_instr_i.use_pc, issue_instr_i.use_imm, issue_instr_i.use_zimm,
     issue_instr_i.ex_valid} = entry.flags;
    // only the two sources have a pending writer
    for (int r = 0; r < 32; r++) begin
      rd_clobber_i[r] = NONE;
    end
    rd_clobber_i[entry.rs1] = entry.clob1;
    rd_clobber_i[entry.rs2] = entry.clob2;
    {rs1_valid_i, rs2_valid_i} = entry.fwd_valid;
    {flu_ready_i, lsu_ready_i, stall_i, flush_i} = entry.ready;
  endtask

  // --------------------
  // stimulus table
  // --------------------
  initial begin
    // register file reads, x0 and the x20 clash
    add_row(ALU, ADD, 5'd1, 5'd2, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b10000);
    add_row(ALU, SUB, 5'd17, 5'd31, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b10000);
    add_row(ALU, ADD, 5'd0, 5'd5, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b10000);
    add_row(ALU, ADD, 5'd20, 5'd0, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b10000);
    // forwarding and clobber stalls
    add_row(ALU, ADD, 5'd3, 5'd4, 4'b0000, ALU, NONE, 2'b10, 4'b1100, 1'b1, 5'b10000);
    add_row(ALU, ADD, 5'd3, 5'd4, 4'b0000, NONE, MULT, 2'b01, 4'b1100, 1'b1, 5'b10000);
    add_row(ALU, ADD, 5'd6, 5'd7, 4'b0000, CSR, NONE, 2'b10, 4'b1100, 1'b0, 5'b00000);
    add_row(CSR, SFENCE_VMA, 5'd6, 5'd7, 4'b0000, CSR, CSR, 2'b11, 4'b1100, 1'b1, 5'b00001);
    add_row(ALU, ADD, 5'd8, 5'd9, 4'b0000, LOAD, NONE, 2'b00, 4'b1100, 1'b0, 5'b00000);
    add_row(STORE, SW, 5'd9, 5'd10, 4'b0000, NONE, ALU, 2'b10, 4'b1100, 1'b0, 5'b00000);
    // back-pressure
    add_row(ALU, ADD, 5'd1, 5'd2, 4'b0000, NONE, NONE, 2'b00, 4'b0100, 1'b0, 5'b00000);
    add_row(MULT, MUL, 5'd1, 5'd2, 4'b0000, NONE, NONE, 2'b00, 4'b0100, 1'b0, 5'b00000);
    add_row(CSR, CSR_READ, 5'd1, 5'd2, 4'b0000, NONE, NONE, 2'b00, 4'b0100, 1'b0, 5'b00000);
    add_row(LOAD, LW, 5'd1, 5'd2, 4'b0000, NONE, NONE, 2'b00, 4'b1000, 1'b0, 5'b00000);
    add_row(STORE, SW, 5'd1, 5'd2, 4'b0000, NONE, NONE, 2'b00, 4'b1000, 1'b0, 5'b00000);
    add_row(ALU, ADD, 5'd1, 5'd2, 4'b0000, NONE, NONE, 2'b00, 4'b1110, 1'b0, 5'b00000);
    // exceptions and unit-less entries pass anyway
    add_row(ALU, ADD, 5'd1, 5'd2, 4'b0001, NONE, NONE, 2'b00, 4'b0010, 1'b1, 5'b00000);
    add_row(NONE, ADD, 5'd8, 5'd9, 4'b0000, LOAD, NONE, 2'b00, 4'b0010, 1'b1, 5'b00000);
    add_row(LOAD, LW, 5'd1, 5'd2, 4'b0001, NONE, NONE, 2'b00, 4'b1000, 1'b1, 5'b00000);
    // unit valids, multiply blocking and flush
    add_row(ALU, ADD, 5'd11, 5'd12, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b10000);
    add_row(CTRL_FLOW, EQ, 5'd11, 5'd12, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b01000);
    add_row(MULT, MUL, 5'd11, 5'd12, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b00100);
    add_row(ALU, ADD, 5'd11, 5'd12, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b0, 5'b00000);
    add_row(LOAD, LW, 5'd13, 5'd14, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b00010);
    add_row(STORE, SW, 5'd13, 5'd14, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b00010);
    add_row(CSR, CSR_WRITE, 5'd15, 5'd16, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b00001);
    add_row(ALU, ADD, 5'd15, 5'd16, 4'b0000, NONE, NONE, 2'b00, 4'b1101, 1'b1, 5'b00000);
    add_row(MULT, MUL, 5'd15, 5'd16, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b00100);
    add_row(CTRL_FLOW, NE, 5'd1, 5'd2, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b0, 5'b00000);
    // operand select
    add_row(ALU, ADD, 5'd1, 5'd2, 4'b1000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b10000);
    add_row(CSR, CSR_WRITE, 5'd12, 5'd2, 4'b0010, ALU, NONE, 2'b00, 4'b1100, 1'b1, 5'b00001);
    add_row(ALU, ADD, 5'd1, 5'd2, 4'b0100, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b10000);
    add_row(STORE, SW, 5'd1, 5'd13, 4'b0100, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b00010);
    add_row(CTRL_FLOW, EQ, 5'd1, 5'd13, 4'b0100, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b01000);
    add_row(ALU, ADD, 5'd21, 5'd2, 4'b1010, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b10000);
    add_row(NONE, ADD, 5'd0, 5'd0, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b00000);
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    row_t        row;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] data_a;
    logic [31:0] data_b;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic        exp_stall;
    logic [4:0]  prev_valid;
    logic [31:0] prev_a;
    logic [31:0] prev_b;
    logic [31:0] prev_imm;
    logic [31:0] prev_pc;
    fu_t         prev_fu;
    fu_op_t      prev_op;
    logic [2:0]  prev_tid;
    int          cycles;

    lfsr_q   = 32'hd01f9ed5;
    errors   = 0;
    timeouts = 0;
    for (int r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end
    row = row_t'{NONE, ADD, 5'd0, 5'd0, 4'b0000, NONE, NONE, 2'b00, 4'b1100, 1'b1, 5'b00000};
    drive_row(row, 32'h0, 32'h0, 3'd0);
    issue_instr_valid_i = 1'b0;
    rs1_i               = '0;
    rs2_i               = '0;
    commit_i            = '0;
    rst_ni              = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // idle payload out of reset
    if (valids !== 5'b0) wrong_value("unit valids", 32'(valids), 32'h0);
    if (fu_data_o.fu !== NONE) wrong_value("fu_data_o.fu", 32'(fu_data_o.fu), 32'(NONE));
    if (fu_data_o.operation !== ADD) wrong_value("fu_data_o.operation",
                                                 32'(fu_data_o.operation), 32'(ADD));
    if (fu_data_o.operand_a !== '0) wrong_value("fu_data_o.operand_a", fu_data_o.operand_a, 0);
    if (fu_data_o.operand_b !== '0) wrong_value("fu_data_o.operand_b", fu_data_o.operand_b, 0);

    // fill x1..x31 while port 1 hits x0 in the last pair and is dropped
    for (int r = 1; r < 32; r += 2) begin
      next_rand(data_a);
      next_rand(data_b);
      drive_commit(5'(r), data_a, 5'(r + 1), data_b);
    end
    next_rand(data_a);
    next_rand(data_b);
    drive_commit(5'd20, data_a, 5'd20, data_b);
    commit_i = '0;

    prev_valid = 5'b0;
    prev_a     = '0;
    prev_b     = '0;
    prev_imm   = '0;
    prev_pc    = '0;
    prev_fu    = NONE;
    prev_op    = ADD;
    prev_tid   = '0;
    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      // registered results of the row before
      if (valids !== prev_valid) wrong_value("unit valids", 32'(valids), 32'(prev_valid));
      if (prev_valid != 5'b0) begin
        if (fu_data_o.operand_a !== prev_a) wrong_value("fu_data_o.operand_a",
                                                        fu_data_o.operand_a, prev_a);
        if (fu_data_o.operand_b !== prev_b) wrong_value("fu_data_o.operand_b",
                                                        fu_data_o.operand_b, prev_b);
        if (fu_data_o.imm !== prev_imm) wrong_value("fu_data_o.imm", fu_data_o.imm, prev_imm);
        if (pc_o !== prev_pc) wrong_value("pc_o", pc_o, prev_pc);
        if (fu_data_o.fu !== prev_fu) begin
          wrong_value("fu_data_o.fu", 32'(fu_data_o.fu), 32'(prev_fu));
        end
        if (fu_data_o.operation !== prev_op) begin
          wrong_value("fu_data_o.operation", 32'(fu_data_o.operation), 32'(prev_op));
        end
        if (fu_data_o.trans_id !== prev_tid) begin
          wrong_value("fu_data_o.trans_id", 32'(fu_data_o.trans_id), 32'(prev_tid));
        end
      end
      next_rand(pc);
      next_rand(imm);
      next_rand(fwd_a);
      next_rand(fwd_b);
      drive_row(row, pc, imm, 3'(i));
      rs1_i               = fwd_a;
      rs2_i               = fwd_b;
      issue_instr_valid_i = 1'b1;

      // expected operands of an entry that goes to a unit
      if (row.flags[1]) exp_a = {27'b0, row.rs1};
      else if (row.flags[3]) exp_a = pc;
      else if (row.clob1 != NONE) exp_a = fwd_a;
      else exp_a = shadow[row.rs1];
      if (row.flags[2] && (row.fu != STORE) && (row.fu != CTRL_FLOW)) exp_b = imm;
      else if (row.clob2 != NONE) exp_b = fwd_b;
      else exp_b = shadow[row.rs2];
      exp_stall = row.ready[1]
                | (src_blocked(row.clob1, row.fwd_valid[1], row.op) & !row.flags[1])
                | src_blocked(row.clob2, row.fwd_valid[0], row.op);

      // combinational outputs sampled mid cycle
      #8;
      if (issue_ack_o !== row.exp_ack) wrong_value("issue_ack_o", 32'(issue_ack_o),
                                                   32'(row.exp_ack));
      if (stall_issue_o !== exp_stall) wrong_value("stall_issue_o", 32'(stall_issue_o),
                                                   32'(exp_stall));
      if (rs1_o !== row.rs1) wrong_value("rs1_o", 32'(rs1_o), 32'(row.rs1));
      if (rs2_o !== row.rs2) wrong_value("rs2_o", 32'(rs2_o), 32'(row.rs2));
      if (row.exp_valid != 5'b0) begin
        if (rs1_forwarding_o !== exp_a) wrong_value("rs1_forwarding_o", rs1_forwarding_o, exp_a);
        if (rs2_forwarding_o !== exp_b) wrong_value("rs2_forwarding_o", rs2_forwarding_o, exp_b);
      end
      prev_valid = row.exp_valid;
      prev_a     = exp_a;
      prev_b     = exp_b;
      prev_imm   = imm;
      prev_pc    = pc;
      prev_fu    = row.fu;
      prev_op    = row.op;
      prev_tid   = 3'(i);
      @(posedge clk_i);
      #2;
    end

    // registered valids of the last row
    if (valids !== prev_valid) wrong_value("unit valids", 32'(valids), 32'(prev_valid));

    // let the last pulses leave
    issue_instr_valid_i = 1'b0;
    cycles              = 0;
    while ((valids !== 5'b0) && (cycles < TIMEOUT_CYCLES)) begin
      @(posedge clk_i);
      #2;
      cycles++;
    end
    if (valids !== 5'b0) begin
      $display("timeout: unit valids still high after %0d cycles", cycles);
      timeouts++;
    end

    $display("summary: %0d mismatches, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- bench/issue_read_operands_assert.sv
// --------------------
// concurrent checks on the unit valids of the issue stage
// attached to the top level by the bind at the end
// --------------------
`timescale 1ns/1ps

module issue_read_operands_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic flush_i,
  input logic alu_valid_i,
  input logic branch_valid_i,
  input logic mult_valid_i,
  input logic lsu_valid_i,
  input logic csr_valid_i
);

  logic [4:0] valids;

  assign valids = {alu_valid_i, branch_valid_i, mult_valid_i, lsu_valid_i, csr_valid_i};

  // at most one unit starts per cycle
  one_unit_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(valids)) else $error("more than one unit valid at once");

  // a flush kills what would start in the next cycle
  no_valid_after_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> (valids == 5'b0)) else $error("unit valid right after flush");

  // write-back slot behind a multiply stays free
  no_alu_after_mult: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mult_valid_i |=> !alu_valid_i) else $error("alu valid right after mult valid");

endmodule

bind issue_read_operands issue_read_operands_assert u_issue_read_operands_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .flush_i        (flush_i),
  .alu_valid_i    (alu_valid_o),
  .branch_valid_i (branch_valid_o),
  .mult_valid_i   (mult_valid_o),
  .lsu_valid_i    (lsu_valid_o),
  .csr_valid_i    (csr_valid_o)
);

//--- hw/issue_read_operands.sv
// --------------------
// integer issue and read-operands stage, top level
// joins register file, hazard logic and the ID/EX register
// --------------------
`timescale 1ns/1ps

module issue_read_operands
  import isa_pkg::*;
  import issue_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  input  logic                               stall_i,
  // scoreboard side
  input  issue_entry_t                       issue_instr_i,
  input  logic                               issue_instr_valid_i,
  output logic                               issue_ack_o,
  output logic         [REG_ADDR_W-1:0]      rs1_o,
  input  logic         [XLEN-1:0]            rs1_i,
  input  logic                               rs1_valid_i,
  output logic         [REG_ADDR_W-1:0]      rs2_o,
  input  logic         [XLEN-1:0]            rs2_i,
  input  logic                               rs2_valid_i,
  input  clobber_t                           rd_clobber_i,
  // execute side
  output fu_data_t                           fu_data_o,
  output logic         [XLEN-1:0]            rs1_forwarding_o,
  output logic         [XLEN-1:0]            rs2_forwarding_o,
  output logic         [XLEN-1:0]            pc_o,
  input  logic                               flu_ready_i,
  input  logic                               lsu_ready_i,
  output logic                               alu_valid_o,
  output logic                               branch_valid_o,
  output logic                               mult_valid_o,
  output logic                               lsu_valid_o,
  output logic                               csr_valid_o,
  // commit write-back
  input  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
  output logic                               stall_issue_o
);

  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  fu_data_t        fu_data_n;
  logic            take;

  // entry leaves the scoreboard this cycle
  assign take = issue_instr_valid_i & issue_ack_o;

  // unregistered operands for units that start early
  assign rs1_forwarding_o = fu_data_n.operand_a;
  assign rs2_forwarding_o = fu_data_n.operand_b;

  gpr_file #(
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) u_gpr_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1_o),
    .raddr_b_i (rs2_o),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .commit_i  (commit_i)
  );

  operand_hazard u_operand_hazard (
    .issue_instr_i       (issue_instr_i),
    .issue_instr_valid_i (issue_instr_valid_i),
    .rs1_i               (rs1_i),
    .rs2_i               (rs2_i),
    .rs1_valid_i         (rs1_valid_i),
    .rs2_valid_i         (rs2_valid_i),
    .rd_clobber_i        (rd_clobber_i),
    .rdata_a_i           (rdata_a),
    .rdata_b_i           (rdata_b),
    .flu_ready_i         (flu_ready_i),
    .lsu_ready_i         (lsu_ready_i),
    .stall_i             (stall_i),
    .mult_issued_i       (mult_valid_o),
    .issue_ack_o         (issue_ack_o),
    .stall_o             (stall_issue_o),
    .rs1_o               (rs1_o),
    .rs2_o               (rs2_o),
    .fu_data_n_o         (fu_data_n)
  );

  fu_dispatch u_fu_dispatch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .take_i         (take),
    .ex_valid_i     (issue_instr_i.ex_valid),
    .fu_i           (issue_instr_i.fu),
    .fu_data_n_i    (fu_data_n),
    .pc_i           (issue_instr_i.pc),
    .fu_data_o      (fu_data_o),
    .pc_o           (pc_o),
    .alu_valid_o    (alu_valid_o),
    .branch_valid_o (branch_valid_o),
    .mult_valid_o   (mult_valid_o),
    .lsu_valid_o    (lsu_valid_o),
    .csr_valid_o    (csr_valid_o)
  );

endmodule

//--- hw/fu_dispatch.sv
// --------------------
// ID/EX pipeline register and unit valid pulses
// one cycle from acknowledge to the valid of the selected unit
// --------------------
`timescale 1ns/1ps

module fu_dispatch
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  // entry accepted this cycle
  input  logic            take_i,
  input  logic            ex_valid_i,
  input  fu_t             fu_i,
  input  fu_data_t        fu_data_n_i,
  input  logic [XLEN-1:0] pc_i,
  output fu_data_t        fu_data_o,
  output logic [XLEN-1:0] pc_o,
  output logic            alu_valid_o,
  output logic            branch_valid_o,
  output logic            mult_valid_o,
  output logic            lsu_valid_o,
  output logic            csr_valid_o
);

  // alu, branch, mult, lsu, csr from msb to lsb
  logic [4:0] valid_n;
  logic [4:0] valid_q;

  // --------------------
  // unit select
  // --------------------
  always_comb begin : unit_select
    valid_n = '0;
    // an exception is passed on without starting a unit
    if (take_i && !ex_valid_i) begin
      case (fu_i)
        ALU:         valid_n[4] = 1'b1;
        CTRL_FLOW:   valid_n[3] = 1'b1;
        MULT:        valid_n[2] = 1'b1;
        LOAD, STORE: valid_n[1] = 1'b1;
        CSR:         valid_n[0] = 1'b1;
        default:     valid_n    = '0;
      endcase
    end
    // flush kills whatever would start next cycle
    if (flush_i) begin
      valid_n = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  assign alu_valid_o    = valid_q[4];
  assign branch_valid_o = valid_q[3];
  assign mult_valid_o   = valid_q[2];
  assign lsu_valid_o    = valid_q[1];
  assign csr_valid_o    = valid_q[0];

  // --------------------
  // payload register
  // --------------------
  // loaded every edge, units only look at it under their valid
  always_ff @(posedge clk_i or negedge rst_ni) begin : payload_reg
    if (!rst_ni) begin
      fu_data_o.fu        <= NONE;
      fu_data_o.operation <= ADD;
      fu_data_o.operand_a <= '0;
      fu_data_o.operand_b <= '0;
      fu_data_o.imm       <= '0;
      fu_data_o.trans_id  <= '0;
      pc_o                <= '0;
    end else begin
      fu_data_o           <= fu_data_n_i;
      pc_o                <= pc_i;
    end
  end

endmodule

//--- hw/operand_hazard.sv
// --------------------
// combinational hazard check and operand select for the issue stage
// decides the acknowledge and builds the next execute payload
// --------------------
`timescale 1ns/1ps

module operand_hazard
  import isa_pkg::*;
  import issue_pkg::*;
(
  // entry from the scoreboard
  input  issue_entry_t          issue_instr_i,
  input  logic                  issue_instr_valid_i,
  // forwarding values from the scoreboard
  input  logic [XLEN-1:0]       rs1_i,
  input  logic [XLEN-1:0]       rs2_i,
  input  logic                  rs1_valid_i,
  input  logic                  rs2_valid_i,
  input  clobber_t              rd_clobber_i,
  // register file read data
  input  logic [XLEN-1:0]       rdata_a_i,
  input  logic [XLEN-1:0]       rdata_b_i,
  // unit readiness and external stall
  input  logic                  flu_ready_i,
  input  logic                  lsu_ready_i,
  input  logic                  stall_i,
  // a multiply left the stage in the last cycle
  input  logic                  mult_issued_i,
  output logic                  issue_ack_o,
  output logic                  stall_o,
  // source register addresses
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  output fu_data_t              fu_data_n_o
);

  fu_t  rs1_clobber;
  fu_t  rs2_clobber;
  logic csr_fwd_ok;
  logic forward_rs1;
  logic forward_rs2;
  logic stall;
  logic fu_busy;

  assign rs1_o = issue_instr_i.rs1;
  assign rs2_o = issue_instr_i.rs2;

  // pending writer of each source
  assign rs1_clobber = rd_clobber_i[issue_instr_i.rs1];
  assign rs2_clobber = rd_clobber_i[issue_instr_i.rs2];

  // sfence may take its operands from a csr writer
  assign csr_fwd_ok = (issue_instr_i.op == SFENCE_VMA);

  // --------------------
  // operand availability
  // --------------------
  always_comb begin : operands_available
    stall       = stall_i;
    forward_rs1 = 1'b0;
    forward_rs2 = 1'b0;
    // zimm lives in the rs1 field, nothing to wait for
    if (!issue_instr_i.use_zimm && (rs1_clobber != NONE)) begin
      // csr results are only reachable through the register file
      if (rs1_valid_i && ((rs1_clobber != CSR) || csr_fwd_ok)) begin
        forward_rs1 = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
    if (rs2_clobber != NONE) begin
      if (rs2_valid_i && ((rs2_clobber != CSR) || csr_fwd_ok)) begin
        forward_rs2 = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
  end

  assign stall_o = stall;

  // busy flag of the unit this entry needs
  always_comb begin : unit_busy
    case (issue_instr_i.fu)
      ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // --------------------
  // acknowledge
  // --------------------
  always_comb begin : issue_ack
    issue_ack_o = 1'b0;
    if (issue_instr_valid_i) begin
      if (!stall && !fu_busy) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less entries pass regardless of stall or busy
      if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // keep the fixed latency write-back free behind a multiply
    if (mult_issued_i && (issue_instr_i.fu inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

  // --------------------
  // operand mux
  // --------------------
  always_comb begin : operand_select
    fu_data_n_o.fu        = issue_instr_i.fu;
    fu_data_n_o.operation = issue_instr_i.op;
    fu_data_n_o.trans_id  = issue_instr_i.trans_id;
    fu_data_n_o.imm       = issue_instr_i.result;
    // register file unless forwarded
    fu_data_n_o.operand_a = forward_rs1 ? rs1_i : rdata_a_i;
    fu_data_n_o.operand_b = forward_rs2 ? rs2_i : rdata_b_i;
    if (issue_instr_i.use_pc) begin
      fu_data_n_o.operand_a = XLEN'($signed(issue_instr_i.pc));
    end
    // zimm beats pc
    if (issue_instr_i.use_zimm) begin
      fu_data_n_o.operand_a = {{(XLEN-REG_ADDR_W){1'b0}}, issue_instr_i.rs1};
    end
    // stores and branches keep rs2, their immediate travels in imm
    if (issue_instr_i.use_imm && !(issue_instr_i.fu inside {STORE, CTRL_FLOW})) begin
      fu_data_n_o.operand_b = issue_instr_i.result;
    end
  end

endmodule

//--- hw/gpr_file.sv
// --------------------
// integer register file, 32 x XLEN
// two combinational read ports, one write per commit port
// x0 is hard wired to zero
// --------------------
`timescale 1ns/1ps

module gpr_file
  import isa_pkg::*;
  import issue_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // read side, addresses straight from the entry
  input  logic         [REG_ADDR_W-1:0]       raddr_a_i,
  input  logic         [REG_ADDR_W-1:0]       raddr_b_i,
  output logic         [XLEN-1:0]             rdata_a_o,
  output logic         [XLEN-1:0]             rdata_b_o,
  // write side from commit
  input  commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i
);

  // x0 has no storage
  logic [NR_REGS-1:1][XLEN-1:0] regs_q;
  logic [NR_REGS-1:1][XLEN-1:0] regs_n;

  // --------------------
  // write port merge
  // --------------------
  // ports are walked in rising order so the highest index wins a clash
  always_comb begin : write_merge
    regs_n = regs_q;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      // writes to x0 are dropped
      if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
        regs_n[commit_i[p].waddr] = commit_i[p].wdata;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_store
    if (!rst_ni) begin
      regs_q <= '0;
    end else begin
      regs_q <= regs_n;
    end
  end

  // --------------------
  // read ports
  // --------------------
  // zero latency, a write is seen from the cycle after its edge
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- hw/issue_pkg.sv
// --------------------
// structs passed between scoreboard, issue stage and execute units
// also holds the write-back port format used by commit
// --------------------
package issue_pkg;

  import isa_pkg::*;

  // transaction id tags an entry through the pipeline
  localparam int unsigned TRANS_ID_W = 3;

  // --------------------
  // scoreboard entry
  // --------------------
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    // immediate value of the instruction
    logic [XLEN-1:0]       result;
    fu_t                   fu;
    fu_op_t                op;
    logic [TRANS_ID_W-1:0] trans_id;
    // operand select flags from decode
    logic                  use_pc;
    logic                  use_imm;
    logic                  use_zimm;
    // entry carries an exception, no unit is started
    logic                  ex_valid;
  } issue_entry_t;

  // payload handed to the execute stage
  typedef struct packed {
    fu_t                   fu;
    fu_op_t                operation;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       imm;
    logic [TRANS_ID_W-1:0] trans_id;
  } fu_data_t;

  // one entry per register, names the unit that will write it
  typedef fu_t [NR_REGS-1:0] clobber_t;

  // write-back port from commit
  typedef struct packed {
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
    logic                  we;
  } commit_port_t;

endpackage

//--- hw/isa_pkg.sv
// --------------------
// instruction-set constants for the integer issue stage
// functional unit and operation encodings shared by every block
// --------------------
package isa_pkg;

  // data and register file geometry
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS    = 32;

  // --------------------
  // functional units
  // --------------------
  // NONE marks an entry that needs no unit at all
  typedef enum logic [3:0] {
    NONE      = 4'd0,
    ALU       = 4'd1,
    CTRL_FLOW = 4'd2,
    MULT      = 4'd3,
    LOAD      = 4'd4,
    STORE     = 4'd5,
    CSR       = 4'd6
  } fu_t;

  // --------------------
  // operations
  // --------------------
  // ADD is also the idle value of the execute payload
  typedef enum logic [6:0] {
    ADD        = 7'd0,
    SUB        = 7'd1,
    XORL       = 7'd2,
    ORL        = 7'd3,
    ANDL       = 7'd4,
    SLL        = 7'd5,
    SRL        = 7'd6,
    SRA        = 7'd7,
    EQ         = 7'd8,
    NE         = 7'd9,
    LW         = 7'd10,
    SW         = 7'd11,
    MUL        = 7'd12,
    CSR_READ   = 7'd13,
    CSR_WRITE  = 7'd14,
    SFENCE_VMA = 7'd15
  } fu_op_t;

endpackage
